/* video_pkg.sv */
// Shared definitions for the video generator:
// data and counter types, register numbers,
// the VRAM word union, configuration and raster structs,
// and the sync timing constants
`default_nettype none

package video_pkg;

typedef logic [15:0] word_t;                    // data word
typedef logic [15:0] addr_t;                    // VRAM word address
typedef logic [7:0]  color_t;                   // colour index
typedef logic [10:0] hres_t;                    // horizontal counter
typedef logic [10:0] vres_t;                    // vertical counter
typedef logic [5:0]  reg_num_t;                 // register number
typedef logic        bpp_t;                     // 0 = 4 bpp, 1 = 8 bpp

localparam bpp_t BPP_4 = 1'b0;
localparam bpp_t BPP_8 = 1'b1;

// register numbers
localparam reg_num_t XR_VID_CTRL     = 6'h00;  // border colour in 7:0
localparam reg_num_t XR_VID_INTR     = 6'h03;
localparam reg_num_t XR_VID_LEFT     = 6'h04;
localparam reg_num_t XR_VID_RIGHT    = 6'h05;
localparam reg_num_t XR_SCANLINE     = 6'h08;  // read only
localparam reg_num_t XR_VID_HSIZE    = 6'h0A;  // read only
localparam reg_num_t XR_VID_VSIZE    = 6'h0B;  // read only
localparam reg_num_t XR_PA_GFX_CTRL  = 6'h10;  // colorbase, blank, bpp
localparam reg_num_t XR_PA_DISP_ADDR = 6'h12;
localparam reg_num_t XR_PA_LINE_LEN  = 6'h13;

// sync placement after the visible area
localparam int H_FRONT = 2;                     // pixels
localparam int H_SYNC  = 4;
localparam int V_FRONT = 1;                     // lines
localparam int V_SYNC  = 1;

// one VRAM word seen as pixels, first pixel in the top bits
typedef union packed {
    logic [3:0][3:0] pix4;                      // four 4 bpp indices
    logic [1:0][7:0] pix8;                      // two 8 bpp indices
} pf_word_u;

typedef struct packed {
    color_t border_color;
    hres_t  vid_left;                           // first pixel of window
    hres_t  vid_right;                          // one past last pixel
} vid_cfg_t;

typedef struct packed {
    color_t colorbase;                          // XORed into each index
    logic   blank;                              // playfield off
    bpp_t   bpp;
    addr_t  disp_addr;                          // line 0 address
    word_t  line_len;                           // words between lines
} pf_cfg_t;

typedef struct packed {
    hres_t h_count;
    vres_t v_count;
    logic  h_visible;
    logic  v_visible;
    logic  end_of_line;                         // last cycle of a line
    logic  end_of_frame;                        // last cycle of visible frame
} raster_t;

endpackage

`default_nettype wire

/* video_timing.sv */
// Raster timing: free-running horizontal and vertical counters,
// visibility, end-of-line and end-of-frame strobes, raw syncs
`default_nettype none
`timescale 1ns/1ns

module video_timing import video_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int H_TOTAL   = 800,
    parameter int V_VISIBLE = 480,
    parameter int V_TOTAL   = 525
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    output raster_t     raster_o,
    output logic        hsync_o,                // raw, registered downstream
    output logic        vsync_o
);

hres_t h_count;
vres_t v_count;
logic  last_h;
logic  last_v;

always_comb begin
    last_h = (h_count == hres_t'(H_TOTAL - 1));
    last_v = (v_count == vres_t'(V_TOTAL - 1));

    raster_o.h_count      = h_count;
    raster_o.v_count      = v_count;
    raster_o.h_visible    = (h_count < hres_t'(H_VISIBLE));
    raster_o.v_visible    = (v_count < vres_t'(V_VISIBLE));
    raster_o.end_of_line  = last_h;
    // end of the last visible line, the frame's data is done here
    raster_o.end_of_frame = last_h && (v_count == vres_t'(V_VISIBLE - 1));

    hsync_o = (h_count >= hres_t'(H_VISIBLE + H_FRONT)) &&
              (h_count <  hres_t'(H_VISIBLE + H_FRONT + H_SYNC));
    vsync_o = (v_count >= vres_t'(V_VISIBLE + V_FRONT)) &&
              (v_count <  vres_t'(V_VISIBLE + V_FRONT + V_SYNC));
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count <= '0;
        v_count <= '0;
    end else if (last_h) begin
        h_count <= '0;                          // wrap line
        if (last_v) begin
            v_count <= '0;                      // wrap frame
        end else begin
            v_count <= v_count + 1'b1;
        end
    end else begin
        h_count <= h_count + 1'b1;
    end
end

endmodule

`default_nettype wire

/* video_regs.sv */
// Configuration registers: write decode into the video and
// playfield config structs, registered readback mux,
// interrupt pulse at end of visible frame or on request
`default_nettype none
`timescale 1ns/1ns

module video_regs import video_pkg::*; #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_en_i,
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output word_t           reg_rd_data_o,
    input  wire raster_t    raster_i,
    output vid_cfg_t        vid_cfg_o,
    output pf_cfg_t         pf_cfg_o,
    output logic            video_intr_o
);

word_t rd_data;

// register writes
always_ff @(posedge clk) begin
    if (reset_i) begin
        video_intr_o           <= 1'b0;
        vid_cfg_o.border_color <= 8'h08;            // grey border until set up
        vid_cfg_o.vid_left     <= '0;
        vid_cfg_o.vid_right    <= hres_t'(H_VISIBLE);
        pf_cfg_o.colorbase     <= '0;
        pf_cfg_o.blank         <= 1'b1;             // playfield starts off
        pf_cfg_o.bpp           <= BPP_8;
        pf_cfg_o.disp_addr     <= '0;
        pf_cfg_o.line_len      <= word_t'(H_VISIBLE / 2);
    end else begin
        video_intr_o <= raster_i.end_of_frame;      // lands on first line of vblank
        if (reg_wr_en_i) begin
            case (reg_num_i)
                XR_VID_CTRL: begin
                    vid_cfg_o.border_color <= reg_data_i[7:0];
                end
                XR_VID_INTR: begin
                    video_intr_o <= 1'b1;           // software interrupt
                end
                XR_VID_LEFT: begin
                    vid_cfg_o.vid_left <= hres_t'(reg_data_i);
                end
                XR_VID_RIGHT: begin
                    vid_cfg_o.vid_right <= hres_t'(reg_data_i);
                end
                XR_PA_GFX_CTRL: begin
                    pf_cfg_o.colorbase <= reg_data_i[15:8];
                    pf_cfg_o.blank     <= reg_data_i[7];
                    pf_cfg_o.bpp       <= reg_data_i[4];
                end
                XR_PA_DISP_ADDR: begin
                    pf_cfg_o.disp_addr <= reg_data_i;
                end
                XR_PA_LINE_LEN: begin
                    pf_cfg_o.line_len <= reg_data_i;
                end
                default: begin
                end
            endcase
        end
    end
end

// readback select
always_comb begin
    case (reg_num_i)
        XR_VID_CTRL:     rd_data = {8'h00, vid_cfg_o.border_color};
        XR_VID_LEFT:     rd_data = word_t'(vid_cfg_o.vid_left);
        XR_VID_RIGHT:    rd_data = word_t'(vid_cfg_o.vid_right);
        XR_SCANLINE:     rd_data = word_t'(raster_i.v_count);
        XR_VID_HSIZE:    rd_data = word_t'(H_VISIBLE);
        XR_VID_VSIZE:    rd_data = word_t'(V_VISIBLE);
        XR_PA_GFX_CTRL:  rd_data = {pf_cfg_o.colorbase, pf_cfg_o.blank, 2'b00,
                                    pf_cfg_o.bpp, 4'h0};
        XR_PA_DISP_ADDR: rd_data = pf_cfg_o.disp_addr;
        XR_PA_LINE_LEN:  rd_data = pf_cfg_o.line_len;
        default:         rd_data = '0;              // intr and unused read zero
    endcase
end

always_ff @(posedge clk) begin
    reg_rd_data_o <= rd_data;                       // one cycle after reg_num_i
end

endmodule

`default_nettype wire

/* pf_fetch.sv */
// Playfield fetch: per-line VRAM address generation,
// read pacing against FIFO fill and reads in flight,
// push of returned words into the word FIFO
`default_nettype none
`timescale 1ns/1ns

module pf_fetch import video_pkg::*; #(
    parameter int H_VISIBLE  = 640,
    parameter int V_VISIBLE  = 480,
    parameter int V_TOTAL    = 525,
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                            clk,
    input  wire logic                            reset_i,
    input  wire raster_t                         raster_i,
    input  wire pf_cfg_t                         pf_cfg_i,
    input  wire vid_cfg_t                        vid_cfg_i,
    input  wire logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_i,
    output logic                                 push_o,
    output word_t                                push_data_o,
    output logic                                 vram_sel_o,
    output addr_t                                vram_addr_o,
    input  wire word_t                           vram_data_i
);

hres_t words_left;                                  // reads still to issue this line
hres_t win_width;
hres_t line_words;
addr_t line_addr;                                   // start of current line
addr_t fetch_addr;
logic  rd_pending;                                  // read issued last cycle
logic  first_line;
logic  line_start;

always_comb begin
    // line L is fetched from the hblank of line L-1, line 0 from the last line
    first_line = (raster_i.v_count == vres_t'(V_TOTAL - 1));
    line_start = (raster_i.h_count == hres_t'(H_VISIBLE)) && !pf_cfg_i.blank &&
                 (first_line || (raster_i.v_count < vres_t'(V_VISIBLE - 1)));

    win_width  = vid_cfg_i.vid_right - vid_cfg_i.vid_left;
    line_words = (pf_cfg_i.bpp == BPP_8) ? (win_width >> 1) : (win_width >> 2);

    // hold off when the FIFO could not take the returning word
    vram_sel_o  = (words_left != '0) &&
                  ((int'(fifo_count_i) + int'(rd_pending)) < FIFO_DEPTH);
    vram_addr_o = fetch_addr;

    push_o      = rd_pending;                       // data valid one cycle after sel
    push_data_o = vram_data_i;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        words_left <= '0;
        rd_pending <= 1'b0;
    end else begin
        rd_pending <= vram_sel_o;
        if (line_start) begin
            words_left <= line_words;
        end else if (vram_sel_o) begin
            words_left <= words_left - 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (line_start) begin
        if (first_line) begin
            line_addr  <= pf_cfg_i.disp_addr;
            fetch_addr <= pf_cfg_i.disp_addr;
        end else begin
            line_addr  <= line_addr + pf_cfg_i.line_len;
            fetch_addr <= line_addr + pf_cfg_i.line_len;
        end
    end else if (vram_sel_o) begin
        fetch_addr <= fetch_addr + 1'b1;
    end
end

endmodule

`default_nettype wire

/* pf_word_fifo.sv */
// Small synchronous word FIFO between playfield fetch and
// pixel output, head word shown combinationally
`default_nettype none
`timescale 1ns/1ns

module pf_word_fifo import video_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                        clk,
    input  wire logic                        reset_i,   // also cleared each frame
    input  wire logic                        push_i,
    input  wire word_t                       push_data_i,
    input  wire logic                        pop_i,
    output word_t                            head_o,
    output logic                             empty_o,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]  count_o
);

localparam int PTR_W = $clog2(FIFO_DEPTH);
localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

word_t            mem [FIFO_DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic             do_pop;

always_comb begin
    empty_o = (count_o == '0);
    do_pop  = pop_i && !empty_o;                    // pop on empty ignored
    head_o  = mem[rd_ptr];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        wr_ptr  <= '0;
        rd_ptr  <= '0;
        count_o <= '0;
    end else begin
        if (push_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        count_o <= count_o + CNT_W'(push_i) - CNT_W'(do_pop);
    end
end

always_ff @(posedge clk) begin
    if (push_i) begin
        mem[wr_ptr] <= push_data_i;
    end
end

endmodule

`default_nettype wire

/* pf_pixel_out.sv */
// Pixel output: unpacks the FIFO head word by bpp, applies
// colorbase and border window, registers colour with syncs
`default_nettype none
`timescale 1ns/1ns

module pf_pixel_out import video_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire raster_t    raster_i,
    input  wire logic       hsync_i,
    input  wire logic       vsync_i,
    input  wire vid_cfg_t   vid_cfg_i,
    input  wire pf_cfg_t    pf_cfg_i,
    input  wire word_t      head_i,
    input  wire logic       empty_i,
    output logic            pop_o,
    output color_t          color_index_o,
    output logic            h_blank_o,
    output logic            v_blank_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

logic [1:0] pix_pos;                                // pixel within head word
pf_word_u   word;
color_t     pf_index;
logic       in_window;
logic       draw;
logic       take;
logic       last_pix;

always_comb begin
    word      = head_i;
    in_window = (raster_i.h_count >= vid_cfg_i.vid_left) &&
                (raster_i.h_count <  vid_cfg_i.vid_right);
    draw      = raster_i.h_visible && raster_i.v_visible && in_window && !pf_cfg_i.blank;
    take      = draw && !empty_i;                   // underflow shows border
    if (pf_cfg_i.bpp == BPP_8) begin
        pf_index = word.pix8[~pix_pos[0]];          // high byte first
        last_pix = pix_pos[0];
    end else begin
        pf_index = {4'h0, word.pix4[~pix_pos]};     // high nibble first
        last_pix = (pix_pos == 2'd3);
    end
    pop_o = take && last_pix;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        pix_pos   <= '0;
        hsync_o   <= 1'b0;
        vsync_o   <= 1'b0;
        dv_de_o   <= 1'b0;
        h_blank_o <= 1'b1;
        v_blank_o <= 1'b1;
    end else begin
        hsync_o   <= hsync_i;
        vsync_o   <= vsync_i;
        dv_de_o   <= raster_i.h_visible && raster_i.v_visible;
        h_blank_o <= !raster_i.h_visible;
        v_blank_o <= !raster_i.v_visible;
        if (raster_i.end_of_line) begin
            pix_pos <= '0;                          // each line starts on a word
        end else if (take) begin
            pix_pos <= last_pix ? 2'd0 : pix_pos + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    color_index_o <= take ? (pf_index ^ pf_cfg_i.colorbase) : vid_cfg_i.border_color;
end

endmodule

`default_nettype wire

/* video_gen.sv */
// Video generator top level: raster timing, config registers,
// playfield fetch, word FIFO and pixel output chain
`default_nettype none
`timescale 1ns/1ns

module video_gen import video_pkg::*; #(
    parameter int H_VISIBLE  = 640,
    parameter int H_TOTAL    = 800,
    parameter int V_VISIBLE  = 480,
    parameter int V_TOTAL    = 525,
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_en_i,
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output word_t           reg_rd_data_o,
    output logic            video_intr_o,
    output logic            vram_sel_o,
    output addr_t           vram_addr_o,
    input  wire word_t      vram_data_i,
    output color_t          color_index_o,
    output logic            h_blank_o,
    output logic            v_blank_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

raster_t          raster;
logic             hsync_raw;
logic             vsync_raw;
vid_cfg_t         vid_cfg;
pf_cfg_t          pf_cfg;
logic [CNT_W-1:0] fifo_count;
logic             fifo_push;
word_t            fifo_push_data;
logic             fifo_pop;
word_t            fifo_head;
logic             fifo_empty;
logic             fifo_clear;

assign fifo_clear = reset_i | raster.end_of_frame;   // drop leftovers each frame

video_timing #(
    .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL), .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL)
) u_timing (
    .clk(clk), .reset_i(reset_i), .raster_o(raster), .hsync_o(hsync_raw), .vsync_o(vsync_raw)
);

video_regs #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)) u_regs (
    .clk(clk), .reset_i(reset_i),
    .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
    .reg_rd_data_o(reg_rd_data_o), .raster_i(raster),
    .vid_cfg_o(vid_cfg), .pf_cfg_o(pf_cfg), .video_intr_o(video_intr_o)
);

pf_fetch #(
    .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL), .FIFO_DEPTH(FIFO_DEPTH)
) u_fetch (
    .clk(clk), .reset_i(reset_i), .raster_i(raster), .pf_cfg_i(pf_cfg), .vid_cfg_i(vid_cfg),
    .fifo_count_i(fifo_count), .push_o(fifo_push), .push_data_o(fifo_push_data),
    .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i)
);

pf_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .reset_i(fifo_clear),
    .push_i(fifo_push), .push_data_i(fifo_push_data), .pop_i(fifo_pop),
    .head_o(fifo_head), .empty_o(fifo_empty), .count_o(fifo_count)
);

pf_pixel_out u_pixel_out (
    .clk(clk), .reset_i(reset_i), .raster_i(raster),
    .hsync_i(hsync_raw), .vsync_i(vsync_raw),
    .vid_cfg_i(vid_cfg), .pf_cfg_i(pf_cfg),
    .head_i(fifo_head), .empty_i(fifo_empty), .pop_o(fifo_pop),
    .color_index_o(color_index_o), .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

endmodule

`default_nettype wire

/* tb_video_ref.svh */
// Reference model for the video generator testbench:
// register image, VRAM fill pattern,
// expected pixel index and expected register readback
`ifndef TB_VIDEO_REF_SVH
`define TB_VIDEO_REF_SVH

// register image as last written by the testbench
typedef struct packed {
    color_t border;
    hres_t  left;
    hres_t  right;
    color_t colorbase;
    logic   blank;
    logic   bpp8;                               // 1 = 8 bpp, 0 = 4 bpp
    addr_t  disp_addr;
    word_t  line_len;
} shadow_t;

function automatic word_t vram_word(input addr_t addr);
    logic [31:0] prod;
    prod = 32'(addr) * 32'h0000_0123;
    return prod[15:0] ^ 16'h5A5A;
endfunction

function automatic color_t expected_pixel(input shadow_t cfg, input int line, input int x);
    int     rel;
    int     per_word;
    addr_t  addr;
    word_t  w;
    color_t idx;
    if (cfg.blank || x < int'(cfg.left) || x >= int'(cfg.right)) begin
        return cfg.border;                      // outside window or playfield off
    end
    rel      = x - int'(cfg.left);
    per_word = cfg.bpp8 ? 2 : 4;
    addr     = cfg.disp_addr + addr_t'(line) * cfg.line_len + addr_t'(rel / per_word);
    w        = vram_word(addr);
    if (cfg.bpp8) begin
        idx = (rel % 2 == 0) ? w[15:8] : w[7:0];    // high byte is the first pixel
    end else begin
        idx = {4'h0, w[15 - 4 * (rel % 4) -: 4]};
    end
    return idx ^ cfg.colorbase;
endfunction

// HSIZE and VSIZE come from the testbench's raster size
function automatic word_t expected_reg(input shadow_t cfg, input reg_num_t num, input int line);
    case (num)
        XR_VID_CTRL:     return {8'h00, cfg.border};
        XR_VID_LEFT:     return word_t'(cfg.left);
        XR_VID_RIGHT:    return word_t'(cfg.right);
        XR_SCANLINE:     return word_t'(line);
        XR_VID_HSIZE:    return word_t'(H_VISIBLE);
        XR_VID_VSIZE:    return word_t'(V_VISIBLE);
        XR_PA_GFX_CTRL:  return {cfg.colorbase, cfg.blank, 2'b00, cfg.bpp8, 4'h0};
        XR_PA_DISP_ADDR: return cfg.disp_addr;
        XR_PA_LINE_LEN:  return cfg.line_len;
        default:         return 16'h0000;
    endcase
endfunction

`endif

/* tb_video_gen.sv */
// Testbench for the video generator: clock and reset, VRAM model,
// register stimulus and readback, pixel comparison against the
// reference model, raster and interrupt checks, final report
`default_nettype none
`timescale 1ns/1ns

module tb_video_gen import video_pkg::*; ();

localparam int H_VISIBLE = 16;
localparam int H_TOTAL   = 32;
localparam int V_VISIBLE = 4;
localparam int V_TOTAL   = 8;
localparam int WAIT_MAX  = 2 * H_TOTAL * V_TOTAL;      // cycles allowed per wait

localparam reg_num_t WRITABLE [6] = '{XR_VID_CTRL, XR_VID_LEFT, XR_VID_RIGHT,
                                      XR_PA_GFX_CTRL, XR_PA_DISP_ADDR, XR_PA_LINE_LEN};

`include "tb_video_ref.svh"

logic     clk;
logic     reset_i;
logic     reg_wr_en_i;
reg_num_t reg_num_i;
word_t    reg_data_i;
word_t    reg_rd_data_o;
logic     video_intr_o;
logic     vram_sel_o;
addr_t    vram_addr_o;
word_t    vram_data_i = '0;
color_t   color_index_o;
logic     h_blank_o;
logic     v_blank_o;
logic     hsync_o;
logic     vsync_o;
logic     dv_de_o;

shadow_t  shadow;
logic     check_en;
string    test_name;
int       seed;
int       pix_errors   = 0;
int       reg_errors   = 0;
int       misc_errors  = 0;
int       pix_x        = 0;
int       pix_line     = 0;
color_t   exp_pix;
logic     prev_h_blank = 1'b1;
logic     prev_v_blank = 1'b1;
logic     prev_intr    = 1'b0;
int       hsync_len    = 0;
int       vsync_len    = 0;
int       hsync_count  = 0;
int       intr_count   = 0;
int       ref_h;
int       ref_v;

initial begin
    clk = 1'b0;
    forever begin
        #5 clk = ~clk;
    end
end

video_gen #(
    .H_VISIBLE(H_VISIBLE), .H_TOTAL(H_TOTAL), .V_VISIBLE(V_VISIBLE), .V_TOTAL(V_TOTAL),
    .FIFO_DEPTH(4)
) dut (
    .clk(clk), .reset_i(reset_i),
    .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
    .reg_rd_data_o(reg_rd_data_o), .video_intr_o(video_intr_o),
    .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
    .color_index_o(color_index_o), .h_blank_o(h_blank_o), .v_blank_o(v_blank_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

// VRAM answers one cycle after the select
always @(posedge clk) begin
    if (vram_sel_o) begin
        vram_data_i <= vram_word(vram_addr_o);
    end
end

// raster position model, only for the scanline readback
always @(posedge clk) begin
    if (reset_i) begin
        ref_h <= 0;
        ref_v <= 0;
    end else if (ref_h == H_TOTAL - 1) begin
        ref_h <= 0;
        ref_v <= (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
    end else begin
        ref_h <= ref_h + 1;
    end
end

// pixel compare, position counted from the blank edges
always @(negedge clk) begin
    if (h_blank_o && !prev_h_blank && !v_blank_o) begin
        if (pix_x != H_VISIBLE) begin
            misc_errors++;
            $display("error %s: pixels per line expected %0d, got %0d",
                     test_name, H_VISIBLE, pix_x);
        end
        pix_line++;
    end
    if (v_blank_o && !prev_v_blank && pix_line != V_VISIBLE) begin
        misc_errors++;
        $display("error %s: lines per frame expected %0d, got %0d",
                 test_name, V_VISIBLE, pix_line);
    end
    if (v_blank_o) begin
        pix_line = 0;
    end
    if (h_blank_o) begin
        pix_x = 0;
    end
    if (dv_de_o) begin
        exp_pix = expected_pixel(shadow, pix_line, pix_x);
        if (check_en && color_index_o !== exp_pix) begin
            pix_errors++;
            $display("error %s: line %0d x %0d expected %02h, got %02h",
                     test_name, pix_line, pix_x, exp_pix, color_index_o);
        end
        pix_x++;
    end
    prev_h_blank = h_blank_o;
    prev_v_blank = v_blank_o;
end

// sync widths, interrupt pulses, reads while blanked
always @(negedge clk) begin
    if (hsync_o) begin
        hsync_len++;
    end else if (hsync_len != 0) begin
        if (hsync_len != H_SYNC) begin
            misc_errors++;
            $display("error %s: hsync width expected %0d, got %0d", test_name, H_SYNC, hsync_len);
        end
        hsync_count++;
        hsync_len = 0;
    end
    if (vsync_o) begin
        vsync_len++;
    end else if (vsync_len != 0) begin
        if (vsync_len != V_SYNC * H_TOTAL) begin
            misc_errors++;
            $display("error %s: vsync width expected %0d, got %0d",
                     test_name, V_SYNC * H_TOTAL, vsync_len);
        end
        vsync_len = 0;
    end
    if (video_intr_o && prev_intr) begin
        misc_errors++;
        $display("interrupt stayed high for more than one cycle during %s", test_name);
    end
    if (video_intr_o && !prev_intr) begin
        intr_count++;
    end
    if (vram_sel_o && shadow.blank) begin
        misc_errors++;
        $display("VRAM read issued while the playfield is blanked during %s", test_name);
    end
    prev_intr = video_intr_o;
end

task automatic wait_frame_sync();
    int n;
    n = 0;
    @(negedge clk);
    while (vsync_o === 1'b1 && n < WAIT_MAX) begin
        @(negedge clk);
        n++;
    end
    while (vsync_o !== 1'b1 && n < WAIT_MAX) begin
        @(negedge clk);
        n++;
    end
    if (vsync_o !== 1'b1) begin
        $display("timeout: no vertical sync within %0d cycles during %s", WAIT_MAX, test_name);
        $display("Regression failed");
        $finish;
    end
endtask

task automatic write_reg(input reg_num_t num, input word_t data);
    @(posedge clk);
    reg_wr_en_i <= 1'b1;
    reg_num_i   <= num;
    reg_data_i  <= data;
    @(posedge clk);
    reg_wr_en_i <= 1'b0;
    case (num)
        XR_VID_CTRL:     shadow.border    = data[7:0];
        XR_VID_LEFT:     shadow.left      = hres_t'(data);
        XR_VID_RIGHT:    shadow.right     = hres_t'(data);
        XR_PA_DISP_ADDR: shadow.disp_addr = data;
        XR_PA_LINE_LEN:  shadow.line_len  = data;
        XR_PA_GFX_CTRL: begin
            shadow.colorbase = data[15:8];
            shadow.blank     = data[7];
            shadow.bpp8      = data[4];
        end
        default: begin
        end
    endcase
endtask

task automatic read_check(input reg_num_t num);
    word_t expected;
    @(posedge clk);
    reg_num_i <= num;
    @(negedge clk);
    expected = expected_reg(shadow, num, ref_v);        // line seen with this select
    @(negedge clk);
    if (reg_rd_data_o !== expected) begin
        reg_errors++;
        $display("error %s: register %02h expected %04h, got %04h",
                 test_name, num, expected, reg_rd_data_o);
    end
endtask

// new playfield setup, written during vertical blank
task automatic set_playfield(input logic bpp8, input int left, input int right);
    word_t ctrl;
    ctrl      = word_t'($random(seed));
    ctrl[7:0] = {3'b000, bpp8, 4'h0};                   // playfield on
    write_reg(XR_VID_CTRL, word_t'($random(seed)));
    write_reg(XR_VID_LEFT, word_t'(left));
    write_reg(XR_VID_RIGHT, word_t'(right));
    write_reg(XR_PA_DISP_ADDR, word_t'($random(seed)));
    write_reg(XR_PA_LINE_LEN, word_t'($random(seed)));
    write_reg(XR_PA_GFX_CTRL, ctrl);
endtask

initial begin
    word_t    data;
    reg_num_t num;
    int       c_intr;
    int       c_hsync;
    seed        = 32'h6ff5;
    shadow      = '{border: 8'h08, left: '0, right: hres_t'(H_VISIBLE), colorbase: '0,
                    blank: 1'b1, bpp8: 1'b1, disp_addr: '0, line_len: word_t'(H_VISIBLE / 2)};
    check_en    = 1'b1;
    test_name   = "reset";
    reset_i     <= 1'b1;
    reg_wr_en_i <= 1'b0;
    reg_num_i   <= '0;
    reg_data_i  <= '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    if ({vram_sel_o, video_intr_o, hsync_o, vsync_o, dv_de_o, h_blank_o, v_blank_o}
        !== 7'b0000011) begin
        misc_errors++;
        $display("error %s: outputs in reset expected 03, got %02h", test_name,
                 {vram_sel_o, video_intr_o, hsync_o, vsync_o, dv_de_o, h_blank_o, v_blank_o});
    end
    @(posedge clk);
    reset_i <= 1'b0;
    wait_frame_sync();                                  // first frame all border

    test_name = "regs";
    check_en  = 1'b0;
    for (int i = 0; i < 24; i++) begin
        num  = WRITABLE[$unsigned($random(seed)) % 6];
        data = word_t'($random(seed));
        if (num == XR_PA_GFX_CTRL) begin
            data[7] = 1'b1;                             // playfield stays blanked
        end
        write_reg(num, data);
        read_check(num);
    end
    read_check(XR_VID_HSIZE);
    read_check(XR_VID_VSIZE);
    for (int i = 0; i < 6; i++) begin
        repeat ($unsigned($random(seed)) % 40) @(posedge clk);
        read_check(XR_SCANLINE);
    end

    test_name = "bpp8";
    wait_frame_sync();
    set_playfield(1'b1, 0, H_VISIBLE);
    check_en = 1'b1;
    wait_frame_sync();
    wait_frame_sync();

    test_name = "bpp4";
    set_playfield(1'b0, 0, H_VISIBLE);
    wait_frame_sync();
    wait_frame_sync();

    test_name = "window";
    set_playfield(1'b1, 4, 12);
    wait_frame_sync();
    wait_frame_sync();
    set_playfield(1'b0, 4, 12);
    wait_frame_sync();
    wait_frame_sync();

    test_name = "raster";
    c_intr    = intr_count;
    c_hsync   = hsync_count;
    wait_frame_sync();
    if (intr_count - c_intr != 1 || hsync_count - c_hsync != V_TOTAL) begin
        misc_errors++;
        $display("error %s: interrupts and hsyncs per frame expected 1 %0d, got %0d %0d",
                 test_name, V_TOTAL, intr_count - c_intr, hsync_count - c_hsync);
    end
    c_intr = intr_count;
    write_reg(XR_VID_INTR, 16'h0000);
    @(negedge clk);
    if (video_intr_o !== 1'b1) begin
        misc_errors++;
        $display("error %s: interrupt after write expected 1, got %b", test_name, video_intr_o);
    end
    wait_frame_sync();
    if (intr_count - c_intr != 2) begin
        misc_errors++;
        $display("error %s: interrupts in frame expected 2, got %0d",
                 test_name, intr_count - c_intr);
    end

    $display("pixel errors %0d, register errors %0d, other errors %0d",
             pix_errors, reg_errors, misc_errors);
    if (pix_errors + reg_errors + misc_errors == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule

`default_nettype wire

/* video_gen.f */
+incdir+.
video_pkg.sv
video_timing.sv
video_regs.sv
pf_fetch.sv
pf_word_fifo.sv
pf_pixel_out.sv
video_gen.sv
tb_video_gen.sv

/* Makefile */
# Verilator build and run of the video generator testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_video_gen -f video_gen.f -o tb_video_gen

run: compile
	./obj_dir/tb_video_gen > sim.log 2>&1; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
